// ==== all.f ====
llc_pkg.sv
llc_input_decoder.sv
llc_stall_ctrl.sv
llc_dma_tracker.sv
llc_input_front.sv
tb_llc_input_front.sv

// ==== llc_decode_patterns.txt ====
# name de rtv fl rsv rqv dmv rcp rcv rsp_addr req_addr dma_addr rss ds dw dd rep
#   then expected: look idle do_get_req do_get_dma_req set tag flags
# flags from bit 6 down: rst_get rsp_get req_get dma_req_get rst_res flush_res req_res
# rep repeats a step, the expected set rising by one each time
rsp_first     1 0 0 1 1 0 0 0 abcdef5 1234567 0000000 0 0 0 0 1  1 0 0 0 5 abcdef 20
req_new       1 0 0 0 1 0 0 0 0000000 1234567 0000000 0 0 0 0 1  1 0 1 0 7 123456 10
# Reset walk, then flush walk
rst_cmd       1 1 0 0 0 0 0 0 0000000 0000000 0000000 0 0 0 0 1  0 0 0 0 0 000000 40
rst_walk      1 0 0 1 0 0 0 0 abcdef5 0000000 0000000 0 0 0 0 16 0 0 0 0 0 000000 04
flush_cmd     1 1 1 0 0 0 0 0 0000000 0000000 0000000 0 0 0 0 1  0 0 0 0 0 000000 40
flush_walk    1 0 0 1 0 0 0 0 abcdef5 0000000 0000000 0 0 0 0 16 1 0 0 0 0 000000 02
after_walk    1 0 0 1 0 0 0 0 abcdef5 0000000 0000000 0 0 0 0 1  1 0 0 0 5 abcdef 20
# Request stall and re-issue
stall_start   0 0 0 0 1 0 0 0 0000000 7654321 0000000 1 0 0 0 1  1 0 0 0 5 abcdef 20
req_blocked   1 0 0 0 1 0 0 0 0000000 1111112 0000000 0 0 0 0 1  0 1 0 0 0 000000 00
rsp_match     1 0 0 1 1 0 0 0 7654321 1111112 0000000 0 0 0 0 1  1 0 0 0 1 765432 20
req_reissue   1 0 0 0 1 0 0 0 0000000 1111112 0000000 0 0 0 0 1  1 0 0 0 1 765432 10
req_after     1 0 0 0 1 0 0 0 0000000 1111112 0000000 0 0 0 0 1  1 0 1 0 2 111111 10
# DMA read and write
dma_rd_start  0 0 0 0 0 0 0 0 0000000 0000000 0000000 0 1 0 0 1  1 0 0 0 2 111111 10
rst_blocked   1 1 0 0 0 0 0 0 0000000 0000000 0000000 0 0 0 0 1  1 0 0 0 0 000000 00
dma_rd_recall 1 0 0 0 0 0 1 1 0000000 0000000 0000000 0 0 0 0 1  0 0 0 0 0 000000 00
dma_rd_done   0 0 0 0 0 0 0 0 0000000 0000000 0000000 0 0 0 1 1  1 0 0 0 0 000000 00
dma_req_new   1 0 0 0 0 1 0 0 0000000 0000000 0dead0b 0 0 0 0 1  1 0 0 1 b 0dead0 08
dma_wr_start  0 0 0 0 0 0 0 0 0000000 0000000 0000000 0 1 1 0 1  1 0 0 0 b 0dead0 08
dma_wr_resume 1 0 0 0 0 1 0 0 0000000 0000000 0dead0b 0 0 0 0 1  1 0 0 1 b 0dead0 00
dma_wr_done   0 0 0 0 0 0 0 0 0000000 0000000 0000000 0 0 0 1 1  1 0 0 0 b 0dead0 00
# Recall pending and idle
recall_rsp    1 0 0 1 1 0 1 0 5555559 1234567 0000000 0 0 0 0 1  1 0 0 0 9 555555 20
recall_block  1 0 0 0 1 0 1 0 0000000 1234567 0000000 0 0 0 0 1  0 0 0 0 0 000000 00
all_idle      1 0 0 0 0 0 0 0 0000000 0000000 0000000 0 0 0 0 1  0 1 0 0 0 000000 00

// ==== llc_dma_tracker.sv ====
`timescale 1ns/1ps

module llc_dma_tracker (
    input  logic                clk,
    input  logic                rst,
    input  logic                dma_start,
    input  logic                dma_write,
    input  logic                dma_done,
    input  llc_pkg::line_addr_t dma_req_in_addr,
    input  logic                update_dma_addr_from_req,
    input  logic                set_is_dma_read_to_resume,
    input  logic                set_is_dma_write_to_resume,
    input  logic                clr_is_dma_read_to_resume,
    input  logic                clr_is_dma_write_to_resume,
    output logic                dma_read_pending,
    output logic                dma_write_pending,
    output logic                is_dma_read_to_resume,
    output logic                is_dma_write_to_resume,
    output llc_pkg::line_addr_t dma_addr
);

    //////////////////////////////
    // Open transfer
    //////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dma_read_pending <= 1'b0;
            dma_write_pending <= 1'b0;
        end else if (dma_done) begin
            dma_read_pending <= 1'b0;
            dma_write_pending <= 1'b0;
        end else if (dma_start) begin
            if (dma_write) begin
                dma_write_pending <= 1'b1;
            end else begin
                dma_read_pending <= 1'b1;
            end
        end
    end

    // A decode either sets a resume flag or clears it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            is_dma_read_to_resume <= 1'b0;
            is_dma_write_to_resume <= 1'b0;
        end else begin
            if (set_is_dma_read_to_resume) begin
                is_dma_read_to_resume <= 1'b1;
            end else if (clr_is_dma_read_to_resume) begin
                is_dma_read_to_resume <= 1'b0;
            end
            if (set_is_dma_write_to_resume) begin
                is_dma_write_to_resume <= 1'b1;
            end else if (clr_is_dma_write_to_resume) begin
                is_dma_write_to_resume <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dma_addr <= '0;
        end else if (update_dma_addr_from_req) begin
            dma_addr <= dma_req_in_addr;
        end
    end

    a_one_dma: assert property (@(posedge clk) disable iff (!rst)
        !(dma_read_pending && dma_write_pending))
        else $error("DMA read and write pending together");

endmodule

// ==== llc_input_decoder.sv ====
`timescale 1ns/1ps

module llc_input_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                decode_en,
    input  logic                rst_tb_valid,
    input  logic                rsp_in_valid,
    input  logic                req_in_valid,
    input  logic                dma_req_in_valid,
    input  logic                recall_pending,
    input  logic                recall_valid,
    input  logic                dma_read_pending,
    input  logic                dma_write_pending,
    input  logic                req_pending,
    input  logic                rst_stall,
    input  logic                flush_stall,
    input  logic                req_stall,
    input  logic                req_in_stalled_valid,
    input  logic                is_dma_read_to_resume,
    input  logic                is_dma_write_to_resume,
    input  llc_pkg::line_addr_t rsp_in_addr,
    input  llc_pkg::line_addr_t req_in_addr,
    input  llc_pkg::line_addr_t dma_req_in_addr,
    input  llc_pkg::line_addr_t req_in_stalled_addr,
    input  llc_pkg::line_addr_t dma_addr,
    input  llc_pkg::llc_set_t   rst_flush_stalled_set,
    input  llc_pkg::llc_set_t   req_in_stalled_set,
    input  llc_pkg::llc_tag_t   req_in_stalled_tag,
    output logic                look,
    output logic                idle,
    output llc_pkg::llc_set_t   set,
    output llc_pkg::llc_tag_t   tag,
    output logic                is_rst_to_get,
    output logic                is_rsp_to_get,
    output logic                is_req_to_get,
    output logic                is_dma_req_to_get,
    output logic                is_rst_to_resume,
    output logic                is_flush_to_resume,
    output logic                is_req_to_resume,
    output logic                do_get_req,
    output logic                do_get_dma_req,
    output logic                update_req_in_from_stalled,
    output logic                clr_req_in_stalled_valid,
    output logic                clr_rst_stall,
    output logic                clr_flush_stall,
    output logic                clr_req_stall_decoder,
    output logic                set_is_dma_read_to_resume,
    output logic                set_is_dma_write_to_resume,
    output logic                clr_is_dma_read_to_resume,
    output logic                clr_is_dma_write_to_resume,
    output logic                update_dma_addr_from_req
);

    logic rst_get_next, rsp_get_next, req_get_next, dma_req_get_next;
    logic rst_resume_next, flush_resume_next, req_resume_next;
    llc_pkg::llc_line_u line_sel;
    llc_pkg::llc_set_t  set_q;

    //////////////////////////////
    // Priority select
    //////////////////////////////

    always_comb begin
        rst_get_next = 1'b0;
        rsp_get_next = 1'b0;
        req_get_next = 1'b0;
        dma_req_get_next = 1'b0;
        rst_resume_next = 1'b0;
        flush_resume_next = 1'b0;
        req_resume_next = 1'b0;
        do_get_req = 1'b0;
        do_get_dma_req = 1'b0;
        update_req_in_from_stalled = 1'b0;
        clr_req_in_stalled_valid = 1'b0;
        clr_rst_stall = 1'b0;
        clr_flush_stall = 1'b0;
        clr_req_stall_decoder = 1'b0;
        set_is_dma_read_to_resume = 1'b0;
        set_is_dma_write_to_resume = 1'b0;
        clr_is_dma_read_to_resume = 1'b0;
        clr_is_dma_write_to_resume = 1'b0;
        update_dma_addr_from_req = 1'b0;
        idle = 1'b0;
        line_sel.raw = '0;

        if (decode_en) begin
            clr_is_dma_read_to_resume = 1'b1;  // Resume flags only live for one decode
            clr_is_dma_write_to_resume = 1'b1;
            if (recall_pending) begin
                if (!recall_valid) begin
                    rsp_get_next = rsp_in_valid;
                end else if (req_pending) begin
                    req_resume_next = 1'b1;
                end else if (dma_read_pending) begin
                    set_is_dma_read_to_resume = 1'b1;
                    clr_is_dma_read_to_resume = 1'b0;
                end else if (dma_write_pending) begin
                    set_is_dma_write_to_resume = 1'b1;
                    clr_is_dma_write_to_resume = 1'b0;
                end
            end else if (rst_stall) begin
                rst_resume_next = 1'b1;
            end else if (flush_stall) begin
                flush_resume_next = 1'b1;
            end else if (rst_tb_valid && !dma_read_pending && !dma_write_pending) begin
                rst_get_next = 1'b1;
            end else if (rsp_in_valid) begin
                rsp_get_next = 1'b1;
            end else if (!req_stall && (req_in_stalled_valid || req_in_valid)) begin
                req_get_next = 1'b1;
                if (req_in_stalled_valid) begin  // Held request goes before new ones
                    update_req_in_from_stalled = 1'b1;
                    clr_req_in_stalled_valid = 1'b1;
                end else begin
                    do_get_req = 1'b1;
                end
            end else if (dma_read_pending) begin
                set_is_dma_read_to_resume = 1'b1;
                clr_is_dma_read_to_resume = 1'b0;
            end else if (dma_write_pending) begin
                if (dma_req_in_valid) begin
                    set_is_dma_write_to_resume = 1'b1;
                    clr_is_dma_write_to_resume = 1'b0;
                    do_get_dma_req = 1'b1;
                end
            end else if (dma_req_in_valid && !req_stall) begin
                dma_req_get_next = 1'b1;
                do_get_dma_req = 1'b1;
            end else begin
                idle = 1'b1;
            end

            // Source of the set and tag for this decode
            if (rsp_get_next) begin
                line_sel.raw = rsp_in_addr;
            end else if (req_get_next) begin
                line_sel.raw = update_req_in_from_stalled ? req_in_stalled_addr : req_in_addr;
            end else if (req_resume_next) begin
                line_sel.raw = req_in_stalled_addr;
            end else if (dma_req_get_next) begin
                line_sel.raw = dma_req_in_addr;
                update_dma_addr_from_req = 1'b1;
            end else if (set_is_dma_read_to_resume || set_is_dma_write_to_resume) begin
                line_sel.raw = dma_addr;
            end

            if (rst_resume_next || flush_resume_next) begin
                if (rst_flush_stalled_set == '1) begin  // Last set of the walk
                    clr_rst_stall = 1'b1;
                    clr_flush_stall = 1'b1;
                end
            end else if (rsp_get_next && req_stall &&
                         line_sel.br.tag == req_in_stalled_tag &&
                         line_sel.br.set == req_in_stalled_set) begin
                clr_req_stall_decoder = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Registered choice
    //////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            is_rst_to_get <= 1'b0;
            is_rsp_to_get <= 1'b0;
            is_req_to_get <= 1'b0;
            is_dma_req_to_get <= 1'b0;
            is_rst_to_resume <= 1'b0;
            is_flush_to_resume <= 1'b0;
            is_req_to_resume <= 1'b0;
            set_q <= '0;
            tag <= '0;
        end else if (decode_en) begin
            is_rst_to_get <= rst_get_next;
            is_rsp_to_get <= rsp_get_next;
            is_req_to_get <= req_get_next;
            is_dma_req_to_get <= dma_req_get_next;
            is_rst_to_resume <= rst_resume_next;
            is_flush_to_resume <= flush_resume_next;
            is_req_to_resume <= req_resume_next;
            set_q <= line_sel.br.set;
            tag <= line_sel.br.tag;
        end
    end

    assign look = is_rsp_to_get | is_req_to_get | is_dma_req_to_get | is_flush_to_resume |
                  ((is_dma_read_to_resume | is_dma_write_to_resume) & ~recall_pending);

    // The walk counter names the set while a reset or flush is resumed
    assign set = (is_rst_to_resume | is_flush_to_resume) ? rst_flush_stalled_set : set_q;

    a_one_choice: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({is_rst_to_get, is_rsp_to_get, is_req_to_get, is_dma_req_to_get,
                  is_rst_to_resume, is_flush_to_resume, is_req_to_resume}))
        else $error("More than one decoder choice registered");

endmodule

// ==== llc_input_front.sv ====
`timescale 1ns/1ps

module llc_input_front (
    input  logic                clk,
    input  logic                rst,
    input  logic                decode_en,
    input  logic                rst_tb_valid,
    input  logic                rst_tb_flush,
    input  logic                rsp_in_valid,
    input  logic                req_in_valid,
    input  logic                dma_req_in_valid,
    input  logic                recall_pending,
    input  logic                recall_valid,
    input  llc_pkg::line_addr_t rsp_in_addr,
    input  llc_pkg::line_addr_t req_in_addr,
    input  llc_pkg::line_addr_t dma_req_in_addr,
    input  logic                req_stall_start,
    input  logic                dma_start,
    input  logic                dma_write,
    input  logic                dma_done,
    output logic                look,
    output logic                idle,
    output llc_pkg::llc_set_t   set,
    output llc_pkg::llc_tag_t   tag,
    output logic                is_rst_to_get,
    output logic                is_rsp_to_get,
    output logic                is_req_to_get,
    output logic                is_dma_req_to_get,
    output logic                is_rst_to_resume,
    output logic                is_flush_to_resume,
    output logic                is_req_to_resume,
    output logic                do_get_req,
    output logic                do_get_dma_req
);

    logic rst_stall, flush_stall, req_stall, req_in_stalled_valid, req_pending;
    logic dma_read_pending, dma_write_pending;
    logic is_dma_read_to_resume, is_dma_write_to_resume;
    logic update_req_in_from_stalled, clr_req_in_stalled_valid;
    logic clr_rst_stall, clr_flush_stall, clr_req_stall_decoder;
    logic set_is_dma_read_to_resume, set_is_dma_write_to_resume;
    logic clr_is_dma_read_to_resume, clr_is_dma_write_to_resume;
    logic update_dma_addr_from_req;
    llc_pkg::line_addr_t req_in_stalled_addr, dma_addr;
    llc_pkg::llc_set_t   rst_flush_stalled_set, req_in_stalled_set;
    llc_pkg::llc_tag_t   req_in_stalled_tag;

    llc_input_decoder decoder0 (.*);

    llc_stall_ctrl stall0 (.*);

    llc_dma_tracker dma0 (.*);

endmodule

// ==== llc_pkg.sv ====
package llc_pkg;

    //////////////////////////////
    // Address geometry
    //////////////////////////////

    localparam int ADDR_BITS      = 32;
    localparam int OFFSET_BITS    = 4;
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;
    localparam int LLC_SET_BITS   = 4;
    localparam int LLC_TAG_BITS   = LINE_ADDR_BITS - LLC_SET_BITS;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [LLC_SET_BITS-1:0]   llc_set_t;
    typedef logic [LLC_TAG_BITS-1:0]   llc_tag_t;

    //////////////////////////////
    // Line address views
    //////////////////////////////

    // Tag sits above the set and the byte offset is already stripped
    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
    } llc_line_br_t;

    typedef union packed {
        line_addr_t   raw;
        llc_line_br_t br;
    } llc_line_u;

endpackage

// ==== llc_stall_ctrl.sv ====
`timescale 1ns/1ps

module llc_stall_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                decode_en,
    input  logic                is_rst_to_get,
    input  logic                rst_tb_flush,
    input  logic                is_rst_to_resume,
    input  logic                is_flush_to_resume,
    input  logic                clr_rst_stall,
    input  logic                clr_flush_stall,
    input  logic                req_stall_start,
    input  llc_pkg::line_addr_t req_in_addr,
    input  logic                clr_req_stall_decoder,
    input  logic                update_req_in_from_stalled,
    input  logic                clr_req_in_stalled_valid,
    output logic                rst_stall,
    output logic                flush_stall,
    output llc_pkg::llc_set_t   rst_flush_stalled_set,
    output logic                req_stall,
    output logic                req_in_stalled_valid,
    output llc_pkg::line_addr_t req_in_stalled_addr,
    output llc_pkg::llc_set_t   req_in_stalled_set,
    output llc_pkg::llc_tag_t   req_in_stalled_tag,
    output logic                req_pending
);

    logic decode_q;
    logic take_rst;
    logic step_walk;
    llc_pkg::llc_line_u stalled_line;

    // Registered choice flags hold between decodes, so act only in the cycle after one
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            decode_q <= 1'b0;
        end else begin
            decode_q <= decode_en;
        end
    end

    assign take_rst = decode_q & is_rst_to_get;
    assign step_walk = decode_q & (is_rst_to_resume | is_flush_to_resume);

    //////////////////////////////
    // Reset and flush walk
    //////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall <= 1'b0;
            flush_stall <= 1'b0;
            rst_flush_stalled_set <= '0;
        end else begin
            if (clr_rst_stall) begin
                rst_stall <= 1'b0;
            end
            if (clr_flush_stall) begin
                flush_stall <= 1'b0;
            end
            if (take_rst) begin
                rst_stall <= ~rst_tb_flush;
                flush_stall <= rst_tb_flush;
                rst_flush_stalled_set <= '0;
            end else if (step_walk) begin
                rst_flush_stalled_set <= rst_flush_stalled_set + llc_pkg::llc_set_t'(1);
            end
        end
    end

    //////////////////////////////
    // Stalled request
    //////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_stall <= 1'b0;
            req_in_stalled_valid <= 1'b0;
        end else if (req_stall_start) begin
            req_stall <= 1'b1;
            req_in_stalled_valid <= 1'b1;
        end else begin
            if (clr_req_stall_decoder) begin
                req_stall <= 1'b0;  // Request stays held until it is re-issued
            end
            if (clr_req_in_stalled_valid) begin
                req_in_stalled_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_stall_start) begin
            stalled_line.raw <= req_in_addr;
        end
    end

    assign req_in_stalled_addr = stalled_line.raw;
    assign req_in_stalled_set = stalled_line.br.set;
    assign req_in_stalled_tag = stalled_line.br.tag;
    assign req_pending = req_in_stalled_valid;

    a_one_walk: assert property (@(posedge clk) disable iff (!rst)
        !(rst_stall && flush_stall))
        else $error("Reset and flush stall both set");

    // Re-issue only happens once the matching response has lifted the stall
    a_reissue: assert property (@(posedge clk) disable iff (!rst)
        update_req_in_from_stalled |-> req_in_stalled_valid && !req_stall)
        else $error("Stalled request re-issued while not ready");

endmodule

// ==== tb_llc_input_front.sv ====
`timescale 1ns/1ps

module tb_llc_input_front;

    localparam int MAX_LINES = 200;

    logic                clk;
    logic                rst;
    logic                decode_en;
    logic                rst_tb_valid, rst_tb_flush, rsp_in_valid, req_in_valid;
    logic                dma_req_in_valid, recall_pending, recall_valid;
    logic                req_stall_start, dma_start, dma_write, dma_done;
    llc_pkg::line_addr_t rsp_in_addr, req_in_addr, dma_req_in_addr;
    logic                look, idle, do_get_req, do_get_dma_req;
    llc_pkg::llc_set_t   set;
    llc_pkg::llc_tag_t   tag;
    logic                is_rst_to_get, is_rsp_to_get, is_req_to_get, is_dma_req_to_get;
    logic                is_rst_to_resume, is_flush_to_resume, is_req_to_resume;

    // Fields of one pattern line with stimulus first and expected values after
    string       test_name;
    logic [31:0] de_v, rtv_v, fl_v, rsv_v, rqv_v, dmv_v, rcp_v, rcv_v;
    logic [31:0] rsp_addr_v, req_addr_v, dma_addr_v, rss_v, ds_v, dw_v, dd_v;
    int          rep_v;
    logic [31:0] look_x, idle_x, get_req_x, get_dma_x, set_x, tag_x, flags_x;

    logic [8*256-1:0] line_buf;
    int               fd;
    int               got;
    int               fields;
    int               lines_read;
    int               steps_run;

    llc_input_front dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    // A decode cycle is followed by one quiet cycle so the stall state can follow the choice
    task automatic apply_vector(input int walk_step);
        @(negedge clk);
        decode_en = de_v[0];
        rst_tb_valid = rtv_v[0];
        rst_tb_flush = fl_v[0];  // Held as a level and sampled one cycle after the reset command
        rsp_in_valid = rsv_v[0];
        req_in_valid = rqv_v[0];
        dma_req_in_valid = dmv_v[0];
        recall_pending = rcp_v[0];
        recall_valid = rcv_v[0];
        rsp_in_addr = rsp_addr_v[llc_pkg::LINE_ADDR_BITS-1:0];
        req_in_addr = req_addr_v[llc_pkg::LINE_ADDR_BITS-1:0];
        dma_req_in_addr = dma_addr_v[llc_pkg::LINE_ADDR_BITS-1:0];
        req_stall_start = rss_v[0];
        dma_start = ds_v[0];
        dma_write = dw_v[0];
        dma_done = dd_v[0];
        #2;
        check_value("idle", idle_x, idle);
        check_value("do_get_req", get_req_x, do_get_req);
        check_value("do_get_dma_req", get_dma_x, do_get_dma_req);

        @(negedge clk);
        check_value("look", look_x, look);
        check_value("set", set_x + walk_step, set);  // Walk steps count the set up
        check_value("tag", tag_x, tag);
        check_value("flags", flags_x, {is_rst_to_get, is_rsp_to_get, is_req_to_get,
                                       is_dma_req_to_get, is_rst_to_resume,
                                       is_flush_to_resume, is_req_to_resume});
        decode_en = 1'b0;
        req_stall_start = 1'b0;
        dma_start = 1'b0;
        dma_write = 1'b0;
        dma_done = 1'b0;
        steps_run++;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst = 1'b0;
        decode_en = 1'b0;
        rst_tb_valid = 1'b0;
        rst_tb_flush = 1'b0;
        rsp_in_valid = 1'b0;
        req_in_valid = 1'b0;
        dma_req_in_valid = 1'b0;
        recall_pending = 1'b0;
        recall_valid = 1'b0;
        rsp_in_addr = '0;
        req_in_addr = '0;
        dma_req_in_addr = '0;
        req_stall_start = 1'b0;
        dma_start = 1'b0;
        dma_write = 1'b0;
        dma_done = 1'b0;
        test_name = "reset";
        steps_run = 0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        fd = $fopen("llc_decode_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file llc_decode_patterns.txt");
            stop_on_failure();
        end

        lines_read = 0;
        while (!$feof(fd)) begin
            lines_read++;
            if (lines_read > MAX_LINES) begin
                $display("Pattern file read did not end within %0d lines", MAX_LINES);
                stop_on_failure();
            end
            line_buf = '0;
            got = $fgets(line_buf, fd);
            test_name = "";
            fields = 0;
            if (got > 0) begin
                fields = $sscanf(line_buf,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %h %h %h %h",
                    test_name, de_v, rtv_v, fl_v, rsv_v, rqv_v, dmv_v, rcp_v, rcv_v,
                    rsp_addr_v, req_addr_v, dma_addr_v, rss_v, ds_v, dw_v, dd_v, rep_v,
                    look_x, idle_x, get_req_x, get_dma_x, set_x, tag_x, flags_x);
            end
            if (fields > 0 && test_name.getc(0) == "#") begin
                // Comment line
            end else if (fields == 24) begin
                for (int i = 0; i < rep_v; i++) begin
                    apply_vector(i);
                end
            end else if (fields > 0) begin
                $display("Pattern line %0d could not be parsed", lines_read);
                stop_on_failure();
            end
        end
        $fclose(fd);

        if (steps_run == 0) begin
            $display("No test vectors were found in the pattern file");
            stop_on_failure();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule
